/* source/rate_types_pkg.sv */
package rate_types_pkg;

	// datapath widths
	localparam int RATE_W     = 16;
	localparam int ANGLE_W    = 16;
	localparam int IMU_W      = 16;
	localparam int THROTTLE_W = 12;
	localparam int MOTOR_W    = 12;

	typedef logic signed [RATE_W-1:0]  rate_t;
	typedef logic signed [ANGLE_W-1:0] angle_t;
	typedef logic signed [IMU_W-1:0]   imu_t;
	typedef logic [THROTTLE_W-1:0]     throttle_t;
	typedef logic [MOTOR_W-1:0]        motor_t;

	// per-axis pid steps
	typedef enum logic [2:0] {
		PID_IDLE,
		PID_CALC1,
		PID_CALC2,
		PID_CALC3,
		PID_CALC4,
		PID_COMPLETE
	} pid_state_t;

	// frame steps
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_ERROR,
		SEQ_PID,
		SEQ_MIX
	} seq_state_t;

endpackage

/* source/pid_gains_pkg.sv */
package pid_gains_pkg;

	// pid output limits
	localparam logic signed [15:0] RATE_MIN = -16'sd16384;
	localparam logic signed [15:0] RATE_MAX = 16'sd16383;

	// roll gains
	localparam logic signed [15:0] K_P_ROLL = 16'sd24;
	localparam logic signed [15:0] K_I_ROLL = 16'sd12;
	localparam logic signed [15:0] K_D_ROLL = 16'sd6;

	// pitch shares roll's airframe symmetry
	localparam logic signed [15:0] K_P_PITCH = 16'sd24;
	localparam logic signed [15:0] K_I_PITCH = 16'sd12;
	localparam logic signed [15:0] K_D_PITCH = 16'sd6;

	// yaw is driven by prop torque only, so softer on I and D
	localparam logic signed [15:0] K_P_YAW = 16'sd32;
	localparam logic signed [15:0] K_I_YAW = 16'sd8;
	localparam logic signed [15:0] K_D_YAW = 16'sd4;

	// gain fractional shifts
	localparam logic [3:0] K_P_SHIFT = 4'd4;
	localparam logic [3:0] K_I_SHIFT = 4'd4;
	localparam logic [3:0] K_D_SHIFT = 4'd4;

	// mixer
	localparam int MIX_SHIFT = 3;
	localparam int MOTOR_MAX = 4095;

endpackage

/* source/attitude_error.sv */
`timescale 1ns/1ns

module attitude_error (
	input  logic                    us_clk,
	input  logic                    resetn,
	input  logic                    err_load,
	input  rate_types_pkg::angle_t  target_angle_roll,
	input  rate_types_pkg::angle_t  target_angle_pitch,
	input  rate_types_pkg::angle_t  target_angle_yaw,
	input  rate_types_pkg::angle_t  actual_angle_roll,
	input  rate_types_pkg::angle_t  actual_angle_pitch,
	input  rate_types_pkg::angle_t  actual_angle_yaw,
	output rate_types_pkg::angle_t  angle_err_roll,
	output rate_types_pkg::angle_t  angle_err_pitch,
	output rate_types_pkg::angle_t  angle_err_yaw
);
	import rate_types_pkg::*;

	// target minus actual, one extra bit then saturate
	function automatic angle_t sat_sub(input angle_t target, input angle_t actual);
		logic signed [ANGLE_W:0] diff;
		diff = {target[ANGLE_W-1], target} - {actual[ANGLE_W-1], actual};
		// top two bits disagree on overflow
		if (diff[ANGLE_W] != diff[ANGLE_W-1]) begin
			if (diff[ANGLE_W])
				return {1'b1, {(ANGLE_W-1){1'b0}}};
			else
				return {1'b0, {(ANGLE_W-1){1'b1}}};
		end
		return diff[ANGLE_W-1:0];
	endfunction

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			angle_err_roll  <= '0;
			angle_err_pitch <= '0;
			angle_err_yaw   <= '0;
		end else if (err_load) begin
			angle_err_roll  <= sat_sub(target_angle_roll, actual_angle_roll);
			angle_err_pitch <= sat_sub(target_angle_pitch, actual_angle_pitch);
			angle_err_yaw   <= sat_sub(target_angle_yaw, actual_angle_yaw);
		end
	end

endmodule

/* source/rate_pid.sv */
`timescale 1ns/1ns

module rate_pid #(
	parameter logic signed [15:0] K_P = 16'sd1,
	parameter logic signed [15:0] K_I = 16'sd1,
	parameter logic signed [15:0] K_D = 16'sd1
) (
	input  logic                    us_clk,
	input  logic                    resetn,
	input  logic                    pid_start,
	input  rate_types_pkg::angle_t  angle_error,
	input  rate_types_pkg::rate_t   target_rate,
	input  rate_types_pkg::imu_t    actual_rate,
	output rate_types_pkg::rate_t   rate_cmd,
	output logic                    pid_done
);
	import rate_types_pkg::*;
	import pid_gains_pkg::*;

	pid_state_t state;
	pid_state_t state_next;

	rate_t rate_err;
	rate_t prev_rate_err;
	rate_t err_change;

	// scaled terms
	logic signed [15:0] term_p;
	logic signed [15:0] term_i;
	logic signed [15:0] term_d;

	logic signed [17:0] total;
	rate_t total_clamped;

	// multiply in 32 bits, shift, keep sign plus low 15 bits
	function automatic logic signed [15:0] scale_val(
		input logic signed [15:0] val,
		input logic signed [15:0] gain,
		input logic [3:0] shift
	);
		logic signed [31:0] val_32;
		logic signed [31:0] gain_32;
		logic signed [31:0] product;
		val_32  = val;
		gain_32 = gain;
		product = (val_32 * gain_32) >>> shift;
		return {product[31], product[14:0]};
	endfunction

	always_comb begin
		state_next = state;
		case (state)
			PID_IDLE: begin
				if (pid_start)
					state_next = PID_CALC1;
			end
			PID_CALC1:    state_next = PID_CALC2;
			PID_CALC2:    state_next = PID_CALC3;
			PID_CALC3:    state_next = PID_CALC4;
			PID_CALC4:    state_next = PID_COMPLETE;
			PID_COMPLETE: state_next = PID_IDLE;
			default:      state_next = PID_IDLE;
		endcase
	end

	// clamp to the rate command range
	always_comb begin
		if (total < RATE_MIN)
			total_clamped = RATE_MIN;
		else if (total > RATE_MAX)
			total_clamped = RATE_MAX;
		else
			total_clamped = total[15:0];
	end

	// each step is registered on the edge that enters its state
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state         <= PID_IDLE;
			rate_err      <= '0;
			prev_rate_err <= '0;
			rate_cmd      <= '0;
		end else begin
			state <= state_next;
			case (state_next)
				PID_CALC1: begin
					prev_rate_err <= rate_err;
					// wraps to 16 bits
					rate_err      <= target_rate - actual_rate;
				end
				PID_COMPLETE: rate_cmd <= total_clamped;
				default: ;
			endcase
		end
	end

	always_ff @(posedge us_clk) begin
		case (state_next)
			PID_CALC1: term_i <= scale_val(angle_error, K_I, K_I_SHIFT);
			PID_CALC2: begin
				term_p     <= scale_val(rate_err, K_P, K_P_SHIFT);
				err_change <= rate_err - prev_rate_err;
			end
			PID_CALC3: term_d <= scale_val(err_change, K_D, K_D_SHIFT);
			PID_CALC4: total  <= term_p + term_i + term_d;
			default: ;
		endcase
	end

	assign pid_done = (state == PID_COMPLETE);

endmodule

/* source/motor_mixer.sv */
`timescale 1ns/1ns

module motor_mixer (
	input  logic                       us_clk,
	input  logic                       resetn,
	input  logic                       mix_load,
	input  rate_types_pkg::throttle_t  throttle,
	input  rate_types_pkg::rate_t      rate_roll,
	input  rate_types_pkg::rate_t      rate_pitch,
	input  rate_types_pkg::rate_t      rate_yaw,
	output rate_types_pkg::motor_t     motor_0,
	output rate_types_pkg::motor_t     motor_1,
	output rate_types_pkg::motor_t     motor_2,
	output rate_types_pkg::motor_t     motor_3
);
	import rate_types_pkg::*;
	import pid_gains_pkg::*;

	logic signed [15:0] thr_s;
	logic signed [15:0] roll_s;
	logic signed [15:0] pitch_s;
	logic signed [15:0] yaw_s;

	logic signed [15:0] mix_0;
	logic signed [15:0] mix_1;
	logic signed [15:0] mix_2;
	logic signed [15:0] mix_3;

	// limit a mixed sum to the esc range
	function automatic motor_t clamp_motor(input logic signed [15:0] sum);
		if (sum < 0)
			return '0;
		else if (sum > MOTOR_MAX)
			return motor_t'(MOTOR_MAX);
		else
			return motor_t'(sum);
	endfunction

	// throttle is unsigned, zero extend
	assign thr_s   = $signed({{(16-THROTTLE_W){1'b0}}, throttle});
	assign roll_s  = rate_roll >>> MIX_SHIFT;
	assign pitch_s = rate_pitch >>> MIX_SHIFT;
	assign yaw_s   = rate_yaw >>> MIX_SHIFT;

	// quad-X, motors 0 and 2 spin opposite to 1 and 3
	assign mix_0 = thr_s + roll_s + pitch_s - yaw_s;
	assign mix_1 = thr_s - roll_s + pitch_s + yaw_s;
	assign mix_2 = thr_s - roll_s - pitch_s - yaw_s;
	assign mix_3 = thr_s + roll_s - pitch_s + yaw_s;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			motor_0 <= '0;
			motor_1 <= '0;
			motor_2 <= '0;
			motor_3 <= '0;
		end else if (mix_load) begin
			motor_0 <= clamp_motor(mix_0);
			motor_1 <= clamp_motor(mix_1);
			motor_2 <= clamp_motor(mix_2);
			motor_3 <= clamp_motor(mix_3);
		end
	end

endmodule

/* source/frame_sequencer.sv */
`timescale 1ns/1ns

module frame_sequencer (
	input  logic us_clk,
	input  logic resetn,
	input  logic frame_start,
	input  logic pid_done,
	output logic err_load,
	output logic pid_start,
	output logic mix_load,
	output logic busy,
	output logic frame_done
);
	import rate_types_pkg::*;

	seq_state_t state;
	seq_state_t state_next;

	always_comb begin
		state_next = state;
		case (state)
			SEQ_IDLE: begin
				// starts seen while busy never reach here
				if (frame_start)
					state_next = SEQ_ERROR;
			end
			SEQ_ERROR: begin
				state_next = SEQ_PID;
			end
			SEQ_PID: begin
				if (pid_done)
					state_next = SEQ_MIX;
			end
			SEQ_MIX: begin
				state_next = SEQ_IDLE;
			end
			default: begin
				state_next = SEQ_IDLE;
			end
		endcase
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state     <= SEQ_IDLE;
			pid_start <= 1'b0;
		end else begin
			state     <= state_next;
			// one cycle, right after the errors are captured
			pid_start <= (state == SEQ_ERROR);
		end
	end

	// error registers load as the frame leaves idle
	assign err_load = (state == SEQ_ERROR);

	// rate commands are already registered when pid_done is seen
	assign mix_load = (state == SEQ_PID) && pid_done;

	assign frame_done = (state == SEQ_MIX);
	assign busy       = (state != SEQ_IDLE);

endmodule

/* source/flight_rate_top.sv */
`timescale 1ns/1ns

module flight_rate_top (
	input  logic                       us_clk,
	input  logic                       resetn,
	input  logic                       frame_start,
	input  rate_types_pkg::angle_t     target_angle_roll,
	input  rate_types_pkg::angle_t     target_angle_pitch,
	input  rate_types_pkg::angle_t     target_angle_yaw,
	input  rate_types_pkg::angle_t     actual_angle_roll,
	input  rate_types_pkg::angle_t     actual_angle_pitch,
	input  rate_types_pkg::angle_t     actual_angle_yaw,
	input  rate_types_pkg::rate_t      target_rate_roll,
	input  rate_types_pkg::rate_t      target_rate_pitch,
	input  rate_types_pkg::rate_t      target_rate_yaw,
	input  rate_types_pkg::imu_t       gyro_roll,
	input  rate_types_pkg::imu_t       gyro_pitch,
	input  rate_types_pkg::imu_t       gyro_yaw,
	input  rate_types_pkg::throttle_t  throttle,
	output logic                       busy,
	output logic                       frame_done,
	output rate_types_pkg::motor_t     motor_0,
	output rate_types_pkg::motor_t     motor_1,
	output rate_types_pkg::motor_t     motor_2,
	output rate_types_pkg::motor_t     motor_3,
	output rate_types_pkg::rate_t      rate_cmd_roll,
	output rate_types_pkg::rate_t      rate_cmd_pitch,
	output rate_types_pkg::rate_t      rate_cmd_yaw
);
	import rate_types_pkg::*;
	import pid_gains_pkg::*;

	logic err_load;
	logic pid_start;
	logic pid_done;
	logic mix_load;

	angle_t angle_err_roll;
	angle_t angle_err_pitch;
	angle_t angle_err_yaw;

	frame_sequencer u_seq (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.frame_start (frame_start),
		.pid_done    (pid_done),
		.err_load    (err_load),
		.pid_start   (pid_start),
		.mix_load    (mix_load),
		.busy        (busy),
		.frame_done  (frame_done)
	);

	attitude_error u_err (
		.us_clk             (us_clk),
		.resetn             (resetn),
		.err_load           (err_load),
		.target_angle_roll  (target_angle_roll),
		.target_angle_pitch (target_angle_pitch),
		.target_angle_yaw   (target_angle_yaw),
		.actual_angle_roll  (actual_angle_roll),
		.actual_angle_pitch (actual_angle_pitch),
		.actual_angle_yaw   (actual_angle_yaw),
		.angle_err_roll     (angle_err_roll),
		.angle_err_pitch    (angle_err_pitch),
		.angle_err_yaw      (angle_err_yaw)
	);

	// all three axes run in lockstep, roll's done paces the frame
	rate_pid #(.K_P(K_P_ROLL), .K_I(K_I_ROLL), .K_D(K_D_ROLL)) u_pid_roll (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.pid_start   (pid_start),
		.angle_error (angle_err_roll),
		.target_rate (target_rate_roll),
		.actual_rate (gyro_roll),
		.rate_cmd    (rate_cmd_roll),
		.pid_done    (pid_done)
	);

	rate_pid #(.K_P(K_P_PITCH), .K_I(K_I_PITCH), .K_D(K_D_PITCH)) u_pid_pitch (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.pid_start   (pid_start),
		.angle_error (angle_err_pitch),
		.target_rate (target_rate_pitch),
		.actual_rate (gyro_pitch),
		.rate_cmd    (rate_cmd_pitch),
		.pid_done    ()
	);

	rate_pid #(.K_P(K_P_YAW), .K_I(K_I_YAW), .K_D(K_D_YAW)) u_pid_yaw (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.pid_start   (pid_start),
		.angle_error (angle_err_yaw),
		.target_rate (target_rate_yaw),
		.actual_rate (gyro_yaw),
		.rate_cmd    (rate_cmd_yaw),
		.pid_done    ()
	);

	motor_mixer u_mix (
		.us_clk     (us_clk),
		.resetn     (resetn),
		.mix_load   (mix_load),
		.throttle   (throttle),
		.rate_roll  (rate_cmd_roll),
		.rate_pitch (rate_cmd_pitch),
		.rate_yaw   (rate_cmd_yaw),
		.motor_0    (motor_0),
		.motor_1    (motor_1),
		.motor_2    (motor_2),
		.motor_3    (motor_3)
	);

endmodule

/* dv/flight_rate_properties.sv */
`timescale 1ns/1ns

module flight_rate_properties (
	input logic                    us_clk,
	input logic                    resetn,
	input logic                    frame_done,
	input logic                    done_roll,
	input logic                    done_pitch,
	input logic                    done_yaw,
	input rate_types_pkg::motor_t  motor_0,
	input rate_types_pkg::motor_t  motor_1,
	input rate_types_pkg::motor_t  motor_2,
	input rate_types_pkg::motor_t  motor_3
);

	// failed assertion count
	int fail_count = 0;

	// frame_done is a one-cycle pulse
	frame_done_single: assert property (@(posedge us_clk) disable iff (!resetn)
		frame_done |=> !frame_done)
	else begin
		fail_count++;
		$error("frame_done stayed high for a second cycle");
	end

	// pid instances run in lockstep
	pid_done_agree: assert property (@(posedge us_clk) disable iff (!resetn)
		(done_roll == done_pitch) && (done_roll == done_yaw))
	else begin
		fail_count++;
		$error("pid_done differs between the axes");
	end

	// motors only move as a frame completes
	motor_hold: assert property (@(posedge us_clk) disable iff (!resetn)
		!frame_done |-> $stable({motor_0, motor_1, motor_2, motor_3}))
	else begin
		fail_count++;
		$error("motor command changed outside frame_done");
	end

endmodule

/* dv/flight_rate_tb.sv */
`timescale 1ns/1ns

module flight_rate_tb;
	import rate_types_pkg::*;
	import pid_gains_pkg::*;

	localparam int FRAME_TIMEOUT = 40;
	localparam int KP [3] = '{K_P_ROLL, K_P_PITCH, K_P_YAW};
	localparam int KI [3] = '{K_I_ROLL, K_I_PITCH, K_I_YAW};
	localparam int KD [3] = '{K_D_ROLL, K_D_PITCH, K_D_YAW};

	logic us_clk = 1'b0;
	logic resetn;
	logic frame_start;
	angle_t tgt_angle [3];
	angle_t act_angle [3];
	rate_t tgt_rate [3];
	imu_t gyro [3];
	throttle_t throttle;
	logic busy;
	logic frame_done;
	motor_t motor_0, motor_1, motor_2, motor_3;
	rate_t rate_cmd_roll, rate_cmd_pitch, rate_cmd_yaw;

	int seed;
	int errors;
	int tests_run;
	int tests_failed;
	bit timed_out;
	// model state, previous rate error per axis
	int prev_err [3];
	int exp_cmd [3];
	int exp_motor [4];

	always #4 us_clk = ~us_clk;

	flight_rate_top DUT (
		.*,
		.target_angle_roll  (tgt_angle[0]),
		.target_angle_pitch (tgt_angle[1]),
		.target_angle_yaw   (tgt_angle[2]),
		.actual_angle_roll  (act_angle[0]),
		.actual_angle_pitch (act_angle[1]),
		.actual_angle_yaw   (act_angle[2]),
		.target_rate_roll   (tgt_rate[0]),
		.target_rate_pitch  (tgt_rate[1]),
		.target_rate_yaw    (tgt_rate[2]),
		.gyro_roll          (gyro[0]),
		.gyro_pitch         (gyro[1]),
		.gyro_yaw           (gyro[2])
	);

	bind flight_rate_top flight_rate_properties u_props (
		.*,
		.done_roll  (pid_done),
		.done_pitch (u_pid_pitch.pid_done),
		.done_yaw   (u_pid_yaw.pid_done)
	);

	function automatic int limit(input int v, input int lo, input int hi);
		if (v < lo)
			return lo;
		if (v > hi)
			return hi;
		return v;
	endfunction

	function automatic int wrap16(input int v);
		logic signed [15:0] w;
		w = v[15:0];
		return int'(w);
	endfunction

	// gain multiply, arithmetic shift, sign bit over low 15 bits
	function automatic int scale(input int val, input int g, input int shift);
		int prod;
		logic signed [15:0] kept;
		prod = (val * g) >>> shift;
		kept = {prod[31], prod[14:0]};
		return int'(kept);
	endfunction

	task automatic compare_value(input int expected, input int actual, input string what);
		if (expected !== actual) begin
			$display("CHECK FAILED at %0t ns: %s expected %0d got %0d",
				$time, what, expected, actual);
			errors++;
		end
	endtask

	task automatic compare_outputs(input string tag);
		compare_value(exp_cmd[0], int'(rate_cmd_roll), {tag, " rate_cmd_roll"});
		compare_value(exp_cmd[1], int'(rate_cmd_pitch), {tag, " rate_cmd_pitch"});
		compare_value(exp_cmd[2], int'(rate_cmd_yaw), {tag, " rate_cmd_yaw"});
		compare_value(exp_motor[0], int'(motor_0), {tag, " motor_0"});
		compare_value(exp_motor[1], int'(motor_1), {tag, " motor_1"});
		compare_value(exp_motor[2], int'(motor_2), {tag, " motor_2"});
		compare_value(exp_motor[3], int'(motor_3), {tag, " motor_3"});
	endtask

	// error, pid and mix for the inputs now on the ports
	task automatic model_frame();
		int err;
		int rerr;
		int sum;
		int t;
		int r [3];
		for (int a = 0; a < 3; a++) begin
			err  = limit(int'(tgt_angle[a]) - int'(act_angle[a]), -32768, 32767);
			rerr = wrap16(int'(tgt_rate[a]) - int'(gyro[a]));
			sum  = scale(err, KI[a], int'(K_I_SHIFT)) + scale(rerr, KP[a], int'(K_P_SHIFT))
				+ scale(wrap16(rerr - prev_err[a]), KD[a], int'(K_D_SHIFT));
			prev_err[a] = rerr;
			exp_cmd[a]  = limit(sum, int'(RATE_MIN), int'(RATE_MAX));
			r[a]        = exp_cmd[a] >>> MIX_SHIFT;
		end
		t = int'(throttle);
		exp_motor[0] = limit(t + r[0] + r[1] - r[2], 0, MOTOR_MAX);
		exp_motor[1] = limit(t - r[0] + r[1] + r[2], 0, MOTOR_MAX);
		exp_motor[2] = limit(t - r[0] - r[1] - r[2], 0, MOTOR_MAX);
		exp_motor[3] = limit(t + r[0] - r[1] + r[2], 0, MOTOR_MAX);
	endtask

	// mode 0 small, 1 extreme, 2 full range; thr below zero means random
	task automatic run_frame(input int mode, input int thr, input bit restart,
		output int edges);
		int cycles;
		int s;
		bit seen;
		edges = 0;
		if (timed_out)
			return;
		@(posedge us_clk);
		for (int a = 0; a < 3; a++) begin
			s = ($random(seed) & 1) ? 1 : -1;
			case (mode)
				0: begin
					tgt_angle[a] <= angle_t'($random(seed) % 1000);
					act_angle[a] <= angle_t'($random(seed) % 1000);
					tgt_rate[a]  <= rate_t'($random(seed) % 2000);
					gyro[a]      <= imu_t'($random(seed) % 2000);
				end
				1: begin
					// opposite extremes push every term the same way
					tgt_angle[a] <= (s > 0) ? 16'sh7fff : 16'sh8000;
					act_angle[a] <= (s > 0) ? 16'sh8000 : 16'sh7fff;
					tgt_rate[a]  <= rate_t'(s * 16000);
					gyro[a]      <= imu_t'(-s * 16000 + $random(seed) % 100);
				end
				default: begin
					tgt_angle[a] <= angle_t'($random(seed));
					act_angle[a] <= angle_t'($random(seed));
					tgt_rate[a]  <= rate_t'($random(seed));
					gyro[a]      <= imu_t'($random(seed));
				end
			endcase
		end
		throttle    <= (thr < 0) ? throttle_t'($random(seed)) : throttle_t'(thr);
		frame_start <= 1'b1;
		@(posedge us_clk);
		frame_start <= 1'b0;
		cycles = 0;
		if (restart) begin
			@(negedge us_clk);
			compare_value(1, int'(busy), "busy after accept");
			// lands while the frame is still running
			@(posedge us_clk);
			frame_start <= 1'b1;
			@(negedge us_clk);
			compare_value(1, int'(busy), "busy at second start");
			@(posedge us_clk);
			frame_start <= 1'b0;
			cycles = 2;
		end
		seen = 1'b0;
		while (!seen && cycles < FRAME_TIMEOUT) begin
			@(negedge us_clk);
			cycles++;
			seen = frame_done;
			if (!seen)
				compare_value(1, int'(busy), "busy before frame_done");
		end
		if (!seen) begin
			$display("timeout: frame_done did not arrive within %0d cycles", FRAME_TIMEOUT);
			timed_out = 1'b1;
		end else begin
			edges = cycles - 1;
			model_frame();
			compare_outputs("frame");
		end
	endtask

	task automatic idle_watch(input int n);
		if (timed_out)
			return;
		repeat (n) begin
			@(negedge us_clk);
			compare_value(0, int'(busy), "busy while idle");
			compare_value(0, int'(frame_done), "frame_done while idle");
			compare_outputs("idle");
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before && !timed_out) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d mismatches", name, errors - errors_before);
		end
	endtask

	initial begin
		int edges;
		int base;
		seed = 32'h7c275c15;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		resetn = 1'b0;
		frame_start = 1'b0;
		throttle = '0;
		for (int a = 0; a < 3; a++) begin
			tgt_angle[a] = '0;
			act_angle[a] = '0;
			tgt_rate[a] = '0;
			gyro[a] = '0;
			prev_err[a] = 0;
			exp_cmd[a] = 0;
		end
		for (int m = 0; m < 4; m++)
			exp_motor[m] = 0;
		repeat (8) @(posedge us_clk);
		resetn <= 1'b1;
		@(negedge us_clk);

		base = errors;
		compare_value(0, int'(busy), "busy after reset");
		compare_value(0, int'(frame_done), "frame_done after reset");
		compare_outputs("reset");
		end_test("1 reset state", base);

		base = errors;
		repeat (40) run_frame(0, -1, 1'b0, edges);
		end_test("2 small random frames", base);

		base = errors;
		for (int i = 0; i < 40; i++) begin
			run_frame(1, -1, 1'b0, edges);
			for (int a = 0; a < 3; a++)
				compare_value(1, int'(exp_cmd[a] == RATE_MAX || exp_cmd[a] == RATE_MIN),
					"rate command at a limit");
		end
		end_test("3 saturating frames", base);

		base = errors;
		for (int i = 0; i < 32; i++)
			run_frame(2, (i % 4 == 0) ? 0 : ((i % 4 == 1) ? 4095 : -1), 1'b0, edges);
		end_test("4 mixer and throttle range", base);

		base = errors;
		run_frame(0, -1, 1'b1, edges);
		idle_watch(20);
		end_test("5 start while busy", base);

		base = errors;
		run_frame(0, -1, 1'b0, edges);
		if (!timed_out)
			compare_value(7, edges, "edges from accept to frame_done");
		idle_watch(20);
		end_test("6 latency and hold", base);

		if (DUT.u_props.fail_count != 0) begin
			$display("%0d handshake assertions failed", DUT.u_props.fail_count);
			errors += DUT.u_props.fail_count;
		end
		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* src.f */
source/rate_types_pkg.sv
source/pid_gains_pkg.sv
source/attitude_error.sv
source/rate_pid.sv
source/motor_mixer.sv
source/frame_sequencer.sv
source/flight_rate_top.sv
dv/flight_rate_properties.sv
dv/flight_rate_tb.sv
